// File: common/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int REG_ADDR_W = 5;   // register index width

    // major opcodes
    localparam logic [6:0] OPC_R     = 7'b0110011;  // register ALU ops
    localparam logic [6:0] OPC_I     = 7'b0010011;  // immediate ALU ops and shifts
    localparam logic [6:0] OPC_IL    = 7'b0000011;  // loads
    localparam logic [6:0] OPC_S     = 7'b0100011;  // stores
    localparam logic [6:0] OPC_B     = 7'b1100011;  // conditional branches
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_FENCE = 7'b0001111;  // FENCE, FENCE.I
    localparam logic [6:0] OPC_E     = 7'b1110011;  // ECALL, EBREAK

    // ALU funct3 shared by R and I groups
    localparam logic [2:0] F3_ADD  = 3'b000;  // ADD/SUB
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_XORI = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL/SRA, SRLI/SRAI

    // loads
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // stores
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [2:0] F3_FENCE   = 3'b000;
    localparam logic [2:0] F3_FENCE_I = 3'b001;
    localparam logic [2:0] F3_PRIV    = 3'b000;  // ECALL/EBREAK

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    // op kinds the golden model computes results for
    localparam int KIND_W = 3;
    localparam logic [KIND_W-1:0] KIND_NONE  = 3'd0;
    localparam logic [KIND_W-1:0] KIND_XORI  = 3'd1;
    localparam logic [KIND_W-1:0] KIND_LB    = 3'd2;
    localparam logic [KIND_W-1:0] KIND_BLT   = 3'd3;
    localparam logic [KIND_W-1:0] KIND_AUIPC = 3'd4;

    // one instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_word_u;

endpackage

// File: common/decoded_if.sv
`timescale 1ns/10ps

// one decoded instruction, decode stage to execute stage
interface decoded_if;

    logic                               valid;  // one-cycle strobe with no ready
    logic                               legal;
    logic [rv32i_pkg::KIND_W-1:0]       kind;
    logic [rv32i_pkg::REG_ADDR_W-1:0]   rd;
    logic [rv32i_pkg::XLEN-1:0]         imm;    // sign-extended in the format of the kind
    logic [rv32i_pkg::XLEN-1:0]         pc;
    logic [rv32i_pkg::XLEN-1:0]         rs1_val;
    logic [rv32i_pkg::XLEN-1:0]         rs2_val;
    logic [rv32i_pkg::XLEN-1:0]         load_word;

    modport dec (
        output valid, legal, kind, rd, imm,
        output pc, rs1_val, rs2_val, load_word
    );

    modport exe (
        input valid, legal, kind, rd, imm,
        input pc, rs1_val, rs2_val, load_word
    );

endinterface

// File: hw/decode/legality_check.sv
`timescale 1ns/10ps

module legality_check (
    input  rv32i_pkg::inst_word_u inst_i,
    output logic                  legal_o
);

    logic shift_ok;   // funct7 rule for the I shift group
    logic r_ok;       // funct7/funct3 pairs for R ops
    logic fence_ok;
    logic system_ok;

    // SLLI needs base funct7, SRLI/SRAI take base or alt, the rest are free
    always_comb begin
        case (inst_i.r.funct3)
            rv32i_pkg::F3_SLL: shift_ok = (inst_i.r.funct7 == rv32i_pkg::F7_BASE);
            rv32i_pkg::F3_SR: begin
                shift_ok = inst_i.r.funct7 inside {rv32i_pkg::F7_BASE, rv32i_pkg::F7_ALT};
            end
            default: shift_ok = 1'b1;
        endcase
    end

    // alt funct7 only for SUB and SRA
    assign r_ok = (inst_i.r.funct7 == rv32i_pkg::F7_BASE) ||
                  ((inst_i.r.funct7 == rv32i_pkg::F7_ALT) &&
                   (inst_i.r.funct3 inside {rv32i_pkg::F3_ADD, rv32i_pkg::F3_SR}));

    // FENCE keeps fm at 0000 with any pred/succ, FENCE.I has every other field zero
    assign fence_ok = (inst_i.i.rd == '0) && (inst_i.i.rs1 == '0) &&
                      (((inst_i.i.funct3 == rv32i_pkg::F3_FENCE) &&
                        (inst_i.i.imm[11:8] == 4'b0000)) ||
                       ((inst_i.i.funct3 == rv32i_pkg::F3_FENCE_I) &&
                        (inst_i.i.imm == 12'h000)));

    assign system_ok = (inst_i.i.imm[11:1] == '0) &&  // imm bit 0 picks ECALL or EBREAK
                       (inst_i.i.rs1 == '0) &&
                       (inst_i.i.funct3 == rv32i_pkg::F3_PRIV) &&
                       (inst_i.i.rd == '0);

    always_comb begin
        case (inst_i.r.opcode)
            rv32i_pkg::OPC_LUI,
            rv32i_pkg::OPC_AUIPC: legal_o = 1'b1;
            rv32i_pkg::OPC_JAL:   legal_o = !inst_i.j.imm10_1[0];  // word-aligned target
            rv32i_pkg::OPC_JALR: begin
                legal_o = (inst_i.i.funct3 == rv32i_pkg::F3_JALR) &&
                          (inst_i.i.imm[1:0] == 2'b00);
            end
            rv32i_pkg::OPC_B: begin
                legal_o = (inst_i.b.funct3 inside {rv32i_pkg::F3_BEQ, rv32i_pkg::F3_BNE,
                                                   rv32i_pkg::F3_BLT, rv32i_pkg::F3_BGE,
                                                   rv32i_pkg::F3_BLTU, rv32i_pkg::F3_BGEU}) &&
                          !inst_i.b.imm4_1[0];
            end
            rv32i_pkg::OPC_IL: begin
                legal_o = inst_i.i.funct3 inside {rv32i_pkg::F3_LB, rv32i_pkg::F3_LH,
                                                  rv32i_pkg::F3_LW, rv32i_pkg::F3_LBU,
                                                  rv32i_pkg::F3_LHU};
            end
            rv32i_pkg::OPC_S: begin
                legal_o = inst_i.s.funct3 inside {rv32i_pkg::F3_SB, rv32i_pkg::F3_SH,
                                                  rv32i_pkg::F3_SW};
            end
            rv32i_pkg::OPC_I:     legal_o = shift_ok;
            rv32i_pkg::OPC_R:     legal_o = r_ok;
            rv32i_pkg::OPC_FENCE: legal_o = fence_ok;
            rv32i_pkg::OPC_E:     legal_o = system_ok;
            default:              legal_o = 1'b0;  // unknown major opcode
        endcase
    end

endmodule

// File: hw/decode/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid_i,
    input  logic [rv32i_pkg::XLEN-1:0] inst_i,
    input  logic [rv32i_pkg::XLEN-1:0] pc_i,
    input  logic [rv32i_pkg::XLEN-1:0] rs1_val_i,
    input  logic [rv32i_pkg::XLEN-1:0] rs2_val_i,
    input  logic [rv32i_pkg::XLEN-1:0] load_word_i,
    decoded_if.dec                     dec_o
);

    rv32i_pkg::inst_word_u             word;
    logic                              legal_d;
    logic [rv32i_pkg::KIND_W-1:0]      kind_d;
    logic [rv32i_pkg::XLEN-1:0]        imm_i_ext;
    logic [rv32i_pkg::XLEN-1:0]        imm_b_ext;
    logic [rv32i_pkg::XLEN-1:0]        imm_u_ext;
    logic [rv32i_pkg::XLEN-1:0]        imm_d;

    assign word = inst_i;

    legality_check legality_i (
        .inst_i  (word),
        .legal_o (legal_d)
    );

    assign imm_i_ext = {{20{word.i.imm[11]}}, word.i.imm};
    assign imm_b_ext = {{19{word.b.imm12}}, word.b.imm12, word.b.imm11,
                        word.b.imm10_5, word.b.imm4_1, 1'b0};
    assign imm_u_ext = {word.u.imm31_12, 12'h000};  // already fills the word

    // illegal words never get a kind
    always_comb begin
        kind_d = rv32i_pkg::KIND_NONE;
        if (legal_d) begin
            case (word.r.opcode)
                rv32i_pkg::OPC_I: begin
                    if (word.i.funct3 == rv32i_pkg::F3_XORI) kind_d = rv32i_pkg::KIND_XORI;
                end
                rv32i_pkg::OPC_IL: begin
                    if (word.i.funct3 == rv32i_pkg::F3_LB) kind_d = rv32i_pkg::KIND_LB;
                end
                rv32i_pkg::OPC_B: begin
                    if (word.b.funct3 == rv32i_pkg::F3_BLT) kind_d = rv32i_pkg::KIND_BLT;
                end
                rv32i_pkg::OPC_AUIPC: kind_d = rv32i_pkg::KIND_AUIPC;
                default:              kind_d = rv32i_pkg::KIND_NONE;
            endcase
        end
    end

    always_comb begin
        case (kind_d)
            rv32i_pkg::KIND_XORI,
            rv32i_pkg::KIND_LB:    imm_d = imm_i_ext;
            rv32i_pkg::KIND_BLT:   imm_d = imm_b_ext;
            rv32i_pkg::KIND_AUIPC: imm_d = imm_u_ext;
            default:               imm_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) dec_o.valid <= 1'b0;
        else     dec_o.valid <= in_valid_i;
    end

    // payload of the strobed instruction
    always_ff @(posedge clk) begin
        dec_o.legal     <= legal_d;
        dec_o.kind      <= kind_d;
        dec_o.rd        <= word.r.rd;
        dec_o.imm       <= imm_d;
        dec_o.pc        <= pc_i;
        dec_o.rs1_val   <= rs1_val_i;
        dec_o.rs2_val   <= rs2_val_i;
        dec_o.load_word <= load_word_i;
    end

endmodule

// File: hw/exec/golden_exec.sv
`timescale 1ns/10ps

module golden_exec (
    input  logic                             clk,
    input  logic                             rst,
    decoded_if.exe                           dec_i,
    output logic                             out_valid_o,
    output logic                             legal_o,
    output logic [rv32i_pkg::XLEN-1:0]       result_o,
    output logic [rv32i_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                             we_o,
    output logic [rv32i_pkg::XLEN-1:0]       mem_addr_o,
    output logic [rv32i_pkg::XLEN-1:0]       next_pc_o
);

    logic                             is_xori;
    logic                             is_lb;
    logic                             is_blt;
    logic                             is_auipc;
    logic                             writes_rd;
    logic [rv32i_pkg::XLEN-1:0]       add_base;
    logic [rv32i_pkg::XLEN-1:0]       add_sum;
    logic [rv32i_pkg::XLEN-1:0]       pc_plus4;
    logic [1:0]                       byte_sel;
    logic [7:0]                       lb_byte;
    logic [rv32i_pkg::XLEN-1:0]       lb_data;
    logic                             blt_taken;
    logic [rv32i_pkg::XLEN-1:0]       result_d;
    logic [rv32i_pkg::XLEN-1:0]       mem_addr_d;
    logic [rv32i_pkg::XLEN-1:0]       next_pc_d;
    logic [rv32i_pkg::REG_ADDR_W-1:0] rd_d;
    logic                             we_d;

    assign is_xori  = (dec_i.kind == rv32i_pkg::KIND_XORI);
    assign is_lb    = (dec_i.kind == rv32i_pkg::KIND_LB);
    assign is_blt   = (dec_i.kind == rv32i_pkg::KIND_BLT);
    assign is_auipc = (dec_i.kind == rv32i_pkg::KIND_AUIPC);

    assign writes_rd = is_xori | is_lb | is_auipc;

    // one adder serves the LB address, the AUIPC sum and the branch target
    assign add_base = (is_auipc || is_blt) ? dec_i.pc : dec_i.rs1_val;
    assign add_sum  = add_base + dec_i.imm;
    assign pc_plus4 = dec_i.pc + 32'd4;

    // little-endian byte lane from the low address bits
    assign byte_sel = add_sum[1:0];
    assign lb_byte  = dec_i.load_word[{byte_sel, 3'b000} +: 8];
    assign lb_data  = {{(rv32i_pkg::XLEN-8){lb_byte[7]}}, lb_byte};

    assign blt_taken = $signed(dec_i.rs1_val) < $signed(dec_i.rs2_val);

    always_comb begin
        case (dec_i.kind)
            rv32i_pkg::KIND_XORI:  result_d = dec_i.rs1_val ^ dec_i.imm;
            rv32i_pkg::KIND_LB:    result_d = lb_data;
            rv32i_pkg::KIND_AUIPC: result_d = add_sum;
            default:               result_d = '0;
        endcase
    end

    assign mem_addr_d = is_lb ? add_sum : '0;
    assign next_pc_d  = (is_blt && blt_taken) ? add_sum : pc_plus4;
    assign rd_d       = writes_rd ? dec_i.rd : '0;
    assign we_d       = dec_i.valid && writes_rd && (dec_i.rd != '0);  // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_o <= 1'b0;
            we_o        <= 1'b0;
        end else begin
            out_valid_o <= dec_i.valid;
            we_o        <= we_d;
        end
    end

    always_ff @(posedge clk) begin
        legal_o    <= dec_i.legal;
        result_o   <= result_d;
        rd_o       <= rd_d;
        mem_addr_o <= mem_addr_d;
        next_pc_o  <= next_pc_d;
    end

endmodule

// File: hw/rv32i_golden_top.sv
`timescale 1ns/10ps

// golden model for retired RV32I instructions with two cycles from strobe to result
module rv32i_golden_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid_i,
    input  logic [rv32i_pkg::XLEN-1:0]       inst_i,
    input  logic [rv32i_pkg::XLEN-1:0]       pc_i,
    input  logic [rv32i_pkg::XLEN-1:0]       rs1_val_i,
    input  logic [rv32i_pkg::XLEN-1:0]       rs2_val_i,
    input  logic [rv32i_pkg::XLEN-1:0]       load_word_i,  // word memory returned
    output logic                             out_valid_o,
    output logic                             legal_o,
    output logic [rv32i_pkg::XLEN-1:0]       result_o,
    output logic [rv32i_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                             we_o,
    output logic [rv32i_pkg::XLEN-1:0]       mem_addr_o,
    output logic [rv32i_pkg::XLEN-1:0]       next_pc_o
);

    decoded_if dec_if ();

    // stage 1 finds legality, op kind and immediate
    inst_decoder decoder_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_val_i   (rs1_val_i),
        .rs2_val_i   (rs2_val_i),
        .load_word_i (load_word_i),
        .dec_o       (dec_if.dec)
    );

    // stage 2 computes the golden results
    golden_exec exec_i (
        .clk         (clk),
        .rst         (rst),
        .dec_i       (dec_if.exe),
        .out_valid_o (out_valid_o),
        .legal_o     (legal_o),
        .result_o    (result_o),
        .rd_o        (rd_o),
        .we_o        (we_o),
        .mem_addr_o  (mem_addr_o),
        .next_pc_o   (next_pc_o)
    );

endmodule

// File: test/rv32i_golden_assert.sv
`timescale 1ns/10ps

module rv32i_golden_assert (
    input logic                             clk,
    input logic                             rst,
    input logic                             in_valid_i,
    input logic                             out_valid_i,
    input logic                             legal_i,
    input logic [rv32i_pkg::REG_ADDR_W-1:0] rd_i,
    input logic                             we_i
);

    // fixed two-cycle latency for every strobe
    latency_a: assert property (@(posedge clk) disable iff (rst)
        out_valid_i == $past(in_valid_i, 2))
        else $error("out_valid_o does not follow in_valid_i by two cycles");

    write_a: assert property (@(posedge clk) disable iff (rst)
        we_i |-> (out_valid_i && legal_i && (rd_i != '0)))
        else $error("we_o high without a legal valid result to a nonzero rd");

    // sync reset clears both strobes by the next edge
    reset_a: assert property (@(posedge clk) rst |=> (!out_valid_i && !we_i))
        else $error("out_valid_o or we_o high after a reset cycle");

endmodule

bind rv32i_golden_top rv32i_golden_assert assert_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .out_valid_i (out_valid_o),
    .legal_i     (legal_o),
    .rd_i        (rd_o),
    .we_i        (we_o)
);

// File: test/tb_rv32i_golden.sv
`timescale 1ns/10ps

module tb_rv32i_golden;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;  // after the rising edge
    localparam int VEC_WORDS   = 11;  // words per line of the vector file
    localparam int MAX_VEC     = 64;

    logic        clk;
    logic        rst;
    logic        in_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_val_i;
    logic [31:0] rs2_val_i;
    logic [31:0] load_word_i;
    logic        out_valid_o;
    logic        legal_o;
    logic [31:0] result_o;
    logic [4:0]  rd_o;
    logic        we_o;
    logic [31:0] mem_addr_o;
    logic [31:0] next_pc_o;

    logic [31:0] vec_mem [0:VEC_WORDS*MAX_VEC];  // word 0 is the vector count
    int          exp_q[$];                       // indices of vectors in flight
    int          n_vec;
    int          value_errs;
    int          proto_errs;
    int          checked;

    rv32i_golden_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid_i  (in_valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs1_val_i   (rs1_val_i),
        .rs2_val_i   (rs2_val_i),
        .load_word_i (load_word_i),
        .out_valid_o (out_valid_o),
        .legal_o     (legal_o),
        .result_o    (result_o),
        .rd_o        (rd_o),
        .we_o        (we_o),
        .mem_addr_o  (mem_addr_o),
        .next_pc_o   (next_pc_o)
    );

    // columns are 0 inst, 1 pc, 2 rs1, 3 rs2, 4 load word, 5 legal, 6 result,
    // 7 rd, 8 we, 9 mem address, 10 next pc
    function automatic logic [31:0] vec_word(input int idx, input int col);
        return vec_mem[1 + idx*VEC_WORDS + col];
    endfunction

    task automatic drive_vector(input int idx);
        in_valid_i  = 1'b1;
        inst_i      = vec_word(idx, 0);
        pc_i        = vec_word(idx, 1);
        rs1_val_i   = vec_word(idx, 2);
        rs2_val_i   = vec_word(idx, 3);
        load_word_i = vec_word(idx, 4);
        exp_q.push_back(idx);
    endtask

    task automatic check_field(input int idx, input string field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("Fail vector %0d %s: expected %h, actual %h", idx, field, exp_val, act_val);
            value_errs++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // watchdog sized from the vector count
    initial begin
        wait (n_vec > 0);
        #((n_vec + 10) * CLK_PERIOD);
        $display("timeout with %0d results still outstanding", exp_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        int idx;
        if (!rst && out_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("out_valid_o went high with no instruction in flight at %0t", $time);
                proto_errs++;
            end else begin
                idx = exp_q.pop_front();
                check_field(idx, "legal", vec_word(idx, 5), 32'(legal_o));
                check_field(idx, "result", vec_word(idx, 6), result_o);
                check_field(idx, "rd", vec_word(idx, 7), 32'(rd_o));
                check_field(idx, "we", vec_word(idx, 8), 32'(we_o));
                check_field(idx, "mem_addr", vec_word(idx, 9), mem_addr_o);
                check_field(idx, "next_pc", vec_word(idx, 10), next_pc_o);
                checked++;
            end
        end
    end

    initial begin
        int idx;
        int drain;
        rst         = 1'b1;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        pc_i        = '0;
        rs1_val_i   = '0;
        rs2_val_i   = '0;
        load_word_i = '0;
        value_errs  = 0;
        proto_errs  = 0;
        checked     = 0;
        $readmemh("test/golden_input.txt", vec_mem);
        n_vec = int'(vec_mem[0]);
        if (n_vec < 1 || n_vec > MAX_VEC) begin
            $display("vector file gives %0d vectors, the array holds 1 to %0d", n_vec, MAX_VEC);
            proto_errs++;
            n_vec = 0;
        end
        repeat (2) @(posedge clk);
        #DRIVE_DELAY rst = 1'b0;
        for (idx = 0; idx < n_vec; idx++) begin
            drive_vector(idx);
            @(posedge clk);
            #DRIVE_DELAY;
            if (idx % 10 == 9) begin  // gap cycle with the strobe low
                in_valid_i = 1'b0;
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        in_valid_i = 1'b0;
        drain = 0;
        while (exp_q.size() != 0 && drain < 4) begin
            @(posedge clk);
            drain++;
        end
        repeat (2) @(posedge clk);  // room for a stray late strobe
        if (exp_q.size() != 0) begin
            $display("%0d instructions never produced a result", exp_q.size());
            proto_errs++;
        end
        $display("checked %0d of %0d vectors: %0d value errors, %0d protocol errors",
                 checked, n_vec, value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
common/rv32i_pkg.sv
common/decoded_if.sv
hw/decode/legality_check.sv
hw/decode/inst_decoder.sv
hw/exec/golden_exec.sv
hw/rv32i_golden_top.sv
test/rv32i_golden_assert.sv
test/tb_rv32i_golden.sv

// File: run.sh
#!/bin/sh
# build and run the RV32I golden model testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv32i_golden -f files.f

status=0
./obj_dir/Vtb_rv32i_golden > sim.log 2>&1 || status=$?
cat sim.log

# a failed concurrent assertion stops the run with a nonzero status
if grep -q "SIMULATION FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: test/golden_input.txt
// first word: number of vectors (hex), then one vector per line
// inst pc rs1 rs2 load_word | expected: legal result rd we mem_addr next_pc
00000022
0ff34293 00001000 12345678 00000000 00000000 1 12345687 05 1 00000000 00001004
fff44393 00001004 0f0f0f0f 00000000 00000000 1 f0f0f0f0 07 1 00000000 00001008
8000c013 00001008 00000123 00000000 00000000 1 fffff923 00 0 00000000 0000100c
55514f93 0000100c aaaaaaaa 00000000 00000000 1 aaaaafff 1f 1 00000000 00001010
00058503 00001010 00002000 00000000 8899aabb 1 ffffffbb 0a 1 00002000 00001014
00158603 00001014 00002000 00000000 11223344 1 00000033 0c 1 00002001 00001018
ffe70683 00001018 00003004 00000000 7f9a1234 1 ffffff9a 0d 1 00003002 0000101c
7ff80783 0000101c 00004000 00000000 5a000000 1 0000005a 0f 1 000047ff 00001020
00308003 00001020 00000010 00000000 c3000000 1 ffffffc3 00 0 00000013 00001024
0020c863 00001024 ffffffff 00000001 00000000 1 00000000 00 0 00000000 00001034
0020c863 00001028 00000001 ffffffff 00000000 1 00000000 00 0 00000000 0000102c
fe41cce3 00002000 80000000 7fffffff 00000000 1 00000000 00 0 00000000 00001ff8
fe41cce3 00002004 00000005 00000005 00000000 1 00000000 00 0 00000000 00002008
12345317 00003000 00000000 00000000 00000000 1 12348000 06 1 00000000 00003004
fffff497 00003004 00000000 00000000 00000000 1 00002004 09 1 00000000 00003008
00001017 80000000 00000000 00000000 00000000 1 80001000 00 0 00000000 80000004
80000a17 7ffffffc 00000000 00000000 00000000 1 fffffffc 14 1 00000000 80000000
// legal words outside the four computed kinds
0ff0000f 00004000 00000000 00000000 00000000 1 00000000 00 0 00000000 00004004
00000073 00004004 00000000 00000000 00000000 1 00000000 00 0 00000000 00004008
00100073 00004008 00000000 00000000 00000000 1 00000000 00 0 00000000 0000400c
40315093 0000400c 00000000 00000000 00000000 1 00000000 00 0 00000000 00004010
402081b3 00004010 00000000 00000000 00000000 1 00000000 00 0 00000000 00004014
0020a023 00004014 00000000 00000000 00000000 1 00000000 00 0 00000000 00004018
008000ef 00004018 00000000 00000000 00000000 1 00000000 00 0 00000000 0000401c
abcde2b7 0000401c 00000000 00000000 00000000 1 00000000 00 0 00000000 00004020
000100e7 00004020 00000000 00000000 00000000 1 00000000 00 0 00000000 00004024
0042a203 00004024 00000000 00000000 00000000 1 00000000 00 0 00000000 00004028
// illegal words
0000b003 00005000 00000000 00000000 00000000 0 00000000 00 0 00000000 00005004
02208133 00005004 00000000 00000000 00000000 0 00000000 00 0 00000000 00005008
ffffffff 00005008 00000000 00000000 00000000 0 00000000 00 0 00000000 0000500c
40109093 0000500c 00000000 00000000 00000000 0 00000000 00 0 00000000 00005010
0020c163 00005010 ffffffff 00000001 00000000 0 00000000 00 0 00000000 00005014
000000f3 00005014 00000000 00000000 00000000 0 00000000 00 0 00000000 00005018
8ff0000f 00005018 00000000 00000000 00000000 0 00000000 00 0 00000000 0000501c
